// ==== src/hic_event_pkg.sv ====
//--------------------------------------------------------------------
// Sample path types. All data words are 32 bits wide.
//--------------------------------------------------------------------
`default_nettype none

package hic_event_pkg;

    // Channel count default and data width
    localparam int N_CH_DEFAULT = 8;
    localparam int DATA_W       = 32;

    // Raw sample and signed difference between two samples
    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [DATA_W-1:0] delta_t;

    // Event counter and timebase value
    typedef logic [DATA_W-1:0] count_t;
    typedef logic [DATA_W-1:0] ts_t;

    // Offset of the stub sample pattern
    localparam sample_t SAMPLE_BASE = 32'sh0000_1000;

endpackage

`default_nettype wire

// ==== src/hic_regmap_pkg.sv ====
//--------------------------------------------------------------------
// Byte addresses with bits 1:0 ignored for decode. Per-channel banks
// use a stride of 4 and assume at most 8 channels per bank.
//--------------------------------------------------------------------
`default_nettype none

package hic_regmap_pkg;

    //----------------------------------------------------------------
    // Single registers
    //----------------------------------------------------------------
    localparam logic [31:0] ADR_ID                 = 32'h0000_0000;
    localparam logic [31:0] ADR_VERSION            = 32'h0000_0004;
    localparam logic [31:0] ADR_CTRL               = 32'h0000_0008;
    localparam logic [31:0] ADR_TIME_NOW           = 32'h0000_0010;
    localparam logic [31:0] ADR_ADC_CMD            = 32'h0000_0020;
    localparam logic [31:0] ADR_ADC_SNAPSHOT_COUNT = 32'h0000_0024;
    localparam logic [31:0] ADR_EVT_CFG            = 32'h0000_0080;

    //----------------------------------------------------------------
    // Per-channel banks, channel c at base + 4c
    //----------------------------------------------------------------
    localparam logic [31:0] ADR_ADC_RAW_BASE        = 32'h0000_0040;
    localparam logic [31:0] ADR_EVT_THRESH_BASE     = 32'h0000_00A0;
    localparam logic [31:0] ADR_EVT_COUNT_BASE      = 32'h0000_00C0;
    localparam logic [31:0] ADR_EVT_LAST_DELTA_BASE = 32'h0000_00E0;
    localparam logic [31:0] ADR_EVT_LAST_TS_BASE    = 32'h0000_0100;

    // ASCII "HICH"
    localparam logic [31:0] CHIP_ID      = 32'h4849_4348;
    localparam logic [31:0] CHIP_VERSION = 32'h0000_0001;

    // Field positions
    localparam int CTRL_ENABLE_BIT    = 0;
    localparam int CTRL_START_BIT     = 1;
    localparam int SNAPSHOT_BIT       = 0;
    localparam int EVT_CLR_COUNTS_BIT = 8;
    localparam int EVT_CLR_HIST_BIT   = 9;

endpackage

`default_nettype wire

// ==== src/hic_evt_bus_if.sv ====
//--------------------------------------------------------------------
// Links the snapshot generator, the event channels and the registers.
// Each channel drives only its own element of the result arrays.
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface hic_evt_bus_if
    import hic_event_pkg::*;
#(
    parameter int N_CH = N_CH_DEFAULT
) ();

    // Sample feed
    logic              sample_valid;
    sample_t           sample [N_CH];
    ts_t               ts_now;
    count_t            snapshot_count;

    // Detector config
    logic [N_CH-1:0]   evt_en;
    logic [DATA_W-1:0] thresh [N_CH];
    logic              clear_counts;
    logic              clear_history;

    // Per-channel results
    count_t            count      [N_CH];
    delta_t            last_delta [N_CH];
    ts_t               last_ts    [N_CH];

    modport feed (
        output sample_valid, sample, ts_now, snapshot_count
    );

    modport cfg (
        output evt_en, thresh, clear_counts, clear_history,
        input  ts_now, snapshot_count, sample, count, last_delta, last_ts
    );

    modport chan (
        input  sample_valid, sample, ts_now, evt_en, thresh,
        input  clear_counts, clear_history,
        output count, last_delta, last_ts
    );

endinterface

`default_nettype wire

// ==== src/hic_snapshot_gen.sv ====
//--------------------------------------------------------------------
// Stub sample source. Samples follow base + count + channel and are
// valid for the one cycle after a snapshot request.
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module hic_snapshot_gen
    import hic_event_pkg::*;
#(
    parameter int N_CH = N_CH_DEFAULT
) (
    input  logic wb_clk_i,
    input  logic wb_rst_i,
    input  logic snapshot_fire_i,
    hic_evt_bus_if.feed bus
);

    ts_t    time_q;
    count_t snap_cnt_q;
    logic   valid_q;

    // Free-running timebase, wraps at 2^32
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            time_q <= '0;
        end else begin
            time_q <= time_q + 1'b1;
        end
    end

    // Snapshot counter moves on the accept edge so the new count
    // is already in place while sample_valid is high
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            snap_cnt_q <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= snapshot_fire_i;
            if (snapshot_fire_i) begin
                snap_cnt_q <= snap_cnt_q + 1'b1;
            end
        end
    end

    assign bus.sample_valid   = valid_q;
    assign bus.ts_now         = time_q;
    assign bus.snapshot_count = snap_cnt_q;

    // Deterministic pattern per channel
    for (genvar c = 0; c < N_CH; c++) begin : g_sample
        assign bus.sample[c] = SAMPLE_BASE + sample_t'(snap_cnt_q) + sample_t'(c);
    end

endmodule

`default_nettype wire

// ==== src/hic_evt_channel.sv ====
//--------------------------------------------------------------------
// One event detector. The first sample after reset or a history clear
// only primes the previous value and never counts as an event.
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module hic_evt_channel
    import hic_event_pkg::*;
#(
    parameter int N_CH = N_CH_DEFAULT,
    parameter int CH   = 0
) (
    input  logic wb_clk_i,
    input  logic wb_rst_i,
    hic_evt_bus_if.chan bus
);

    logic [N_CH-1:0] en_mask;
    logic            enabled;
    sample_t         prev_q;
    logic            have_prev_q;
    count_t          count_q;
    delta_t          last_delta_q;
    ts_t             last_ts_q;
    delta_t          delta;
    logic [DATA_W-1:0] abs_delta;
    logic            hit;

    assign en_mask = bus.evt_en;
    assign enabled = en_mask[CH];

    //----------------------------------------------------------------
    // Delta and threshold compare
    //----------------------------------------------------------------
    assign delta     = bus.sample[CH] - prev_q;
    assign abs_delta = delta[DATA_W-1] ? DATA_W'(-delta) : DATA_W'(delta);
    // Unsigned compare, so threshold 0 fires on every sample
    assign hit       = have_prev_q && (abs_delta >= bus.thresh[CH]);

    //----------------------------------------------------------------
    // State update
    //----------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            prev_q       <= '0;
            have_prev_q  <= 1'b0;
            count_q      <= '0;
            last_delta_q <= '0;
            last_ts_q    <= '0;
        end else if (bus.clear_counts || bus.clear_history) begin
            // Clears take priority over a sample in the same cycle
            if (bus.clear_counts) begin
                count_q <= '0;
            end
            if (bus.clear_history) begin
                prev_q       <= '0;
                have_prev_q  <= 1'b0;
                last_delta_q <= '0;
                last_ts_q    <= '0;
            end
        end else if (bus.sample_valid && enabled) begin
            if (hit) begin
                count_q      <= count_q + 1'b1;
                last_delta_q <= delta;
                last_ts_q    <= bus.ts_now;
            end
            prev_q      <= bus.sample[CH];
            have_prev_q <= 1'b1;
        end
    end

    assign bus.count[CH]      = count_q;
    assign bus.last_delta[CH] = last_delta_q;
    assign bus.last_ts[CH]    = last_ts_q;

endmodule

`default_nettype wire

// ==== src/hic_wb_regs.sv ====
//--------------------------------------------------------------------
// Wishbone slave, one transfer every two cycles, no stall. The master
// drops stb after ack. Write-1 pulse bits honour their byte lane.
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module hic_wb_regs
    import hic_regmap_pkg::*, hic_event_pkg::*;
#(
    parameter int N_CH = N_CH_DEFAULT
) (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        wbs_cyc_i,
    input  logic        wbs_stb_i,
    input  logic        wbs_we_i,
    input  logic [3:0]  wbs_sel_i,
    input  logic [31:0] wbs_adr_i,
    input  logic [31:0] wbs_dat_i,
    output logic        wbs_ack_o,
    output logic [31:0] wbs_dat_o,
    output logic        ctrl_enable_o,
    output logic        ctrl_start_o,
    output logic        snapshot_fire_o,
    hic_evt_bus_if.cfg  bus
);

    logic              wb_valid;
    logic              wb_fire;
    logic              wr_fire;
    logic [31:0]       adr_w;
    logic [2:0]        ch_idx;
    logic              ch_ok;
    logic [31:0]       rd_data;
    logic              start_req;
    logic              clr_counts_req;
    logic              clr_hist_req;

    logic              enable_q;
    logic              start_pend_q;
    logic              start_q;
    logic              clr_counts_q;
    logic              clr_hist_q;
    logic [N_CH-1:0]   evt_en_q;
    logic [DATA_W-1:0] thresh_q [N_CH];

    // Byte-lane merge of write data into the current value
    function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
                                                input logic [31:0] wdat,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = cur;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wdat[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Banks are 32-byte aligned, so the upper bits select the bank
    function automatic logic in_bank(input logic [31:0] adr, input logic [31:0] base);
        return adr[31:5] == base[31:5];
    endfunction

    //----------------------------------------------------------------
    // Handshake and decode
    //----------------------------------------------------------------
    assign wb_valid = wbs_cyc_i & wbs_stb_i;
    assign wb_fire  = wb_valid & ~wbs_ack_o;
    assign wr_fire  = wb_fire & wbs_we_i;
    assign adr_w    = {wbs_adr_i[31:2], 2'b00};
    assign ch_idx   = wbs_adr_i[4:2];
    assign ch_ok    = int'(ch_idx) < N_CH;

    // Write-1 request bits, each gated by its own byte lane
    assign start_req = wr_fire && (adr_w == ADR_CTRL)
                       && wbs_sel_i[CTRL_START_BIT / 8] && wbs_dat_i[CTRL_START_BIT];
    assign snapshot_fire_o = wr_fire && (adr_w == ADR_ADC_CMD)
                             && wbs_sel_i[SNAPSHOT_BIT / 8] && wbs_dat_i[SNAPSHOT_BIT];
    assign clr_counts_req = wr_fire && (adr_w == ADR_EVT_CFG)
                            && wbs_sel_i[EVT_CLR_COUNTS_BIT / 8]
                            && wbs_dat_i[EVT_CLR_COUNTS_BIT];
    assign clr_hist_req = wr_fire && (adr_w == ADR_EVT_CFG)
                          && wbs_sel_i[EVT_CLR_HIST_BIT / 8]
                          && wbs_dat_i[EVT_CLR_HIST_BIT];

    //----------------------------------------------------------------
    // Registers
    //----------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o    <= 1'b0;
            wbs_dat_o    <= '0;
            enable_q     <= 1'b0;
            start_pend_q <= 1'b0;
            start_q      <= 1'b0;
            clr_counts_q <= 1'b0;
            clr_hist_q   <= 1'b0;
            evt_en_q     <= '0;
            for (int c = 0; c < N_CH; c++) begin
                thresh_q[c] <= '0;
            end
        end else begin
            wbs_ack_o <= wb_valid & ~wbs_ack_o;
            if (wb_fire) begin
                wbs_dat_o <= rd_data;
            end

            // START lands one cycle after ack
            start_pend_q <= start_req;
            start_q      <= start_pend_q;
            clr_counts_q <= clr_counts_req;
            clr_hist_q   <= clr_hist_req;

            if (wr_fire && (adr_w == ADR_CTRL) && wbs_sel_i[CTRL_ENABLE_BIT / 8]) begin
                enable_q <= wbs_dat_i[CTRL_ENABLE_BIT];
            end
            // Enable mask sits in byte lane 0
            if (wr_fire && (adr_w == ADR_EVT_CFG) && wbs_sel_i[0]) begin
                evt_en_q <= wbs_dat_i[N_CH-1:0];
            end
            if (wr_fire && ch_ok && in_bank(adr_w, ADR_EVT_THRESH_BASE)) begin
                thresh_q[ch_idx] <= merge_bytes(thresh_q[ch_idx], wbs_dat_i, wbs_sel_i);
            end
        end
    end

    //----------------------------------------------------------------
    // Read mux
    //----------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        if (ch_ok && in_bank(adr_w, ADR_ADC_RAW_BASE)) begin
            rd_data = bus.sample[ch_idx];
        end else if (ch_ok && in_bank(adr_w, ADR_EVT_THRESH_BASE)) begin
            rd_data = thresh_q[ch_idx];
        end else if (ch_ok && in_bank(adr_w, ADR_EVT_COUNT_BASE)) begin
            rd_data = bus.count[ch_idx];
        end else if (ch_ok && in_bank(adr_w, ADR_EVT_LAST_DELTA_BASE)) begin
            rd_data = bus.last_delta[ch_idx];
        end else if (ch_ok && in_bank(adr_w, ADR_EVT_LAST_TS_BASE)) begin
            rd_data = bus.last_ts[ch_idx];
        end else begin
            case (adr_w)
                ADR_ID:                 rd_data = CHIP_ID;
                ADR_VERSION:            rd_data = CHIP_VERSION;
                // START and the clear bits always read 0
                ADR_CTRL:               rd_data[CTRL_ENABLE_BIT] = enable_q;
                ADR_TIME_NOW:           rd_data = bus.ts_now;
                ADR_ADC_SNAPSHOT_COUNT: rd_data = bus.snapshot_count;
                ADR_EVT_CFG:            rd_data[N_CH-1:0] = evt_en_q;
                default:                rd_data = '0;
            endcase
        end
    end

    assign ctrl_enable_o     = enable_q;
    assign ctrl_start_o      = start_q;
    assign bus.evt_en        = evt_en_q;
    assign bus.thresh        = thresh_q;
    assign bus.clear_counts  = clr_counts_q;
    assign bus.clear_history = clr_hist_q;

endmodule

`default_nettype wire

// ==== src/home_inventory_wb.sv ====
//--------------------------------------------------------------------
// Register block top level. N_CH must not exceed 8 or the banks overlap.
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module home_inventory_wb
    import hic_event_pkg::*;
#(
    parameter int N_CH = N_CH_DEFAULT
) (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        wbs_cyc_i,
    input  logic        wbs_stb_i,
    input  logic        wbs_we_i,
    input  logic [3:0]  wbs_sel_i,
    input  logic [31:0] wbs_adr_i,
    input  logic [31:0] wbs_dat_i,
    output logic        wbs_ack_o,
    output logic [31:0] wbs_dat_o,
    output logic        ctrl_enable_o,
    output logic        ctrl_start_o
);

    logic snapshot_fire;

    hic_evt_bus_if #(.N_CH(N_CH)) evt_bus ();

    hic_wb_regs #(.N_CH(N_CH)) i_hic_wb_regs (
        .wb_clk_i        (wb_clk_i),
        .wb_rst_i        (wb_rst_i),
        .wbs_cyc_i       (wbs_cyc_i),
        .wbs_stb_i       (wbs_stb_i),
        .wbs_we_i        (wbs_we_i),
        .wbs_sel_i       (wbs_sel_i),
        .wbs_adr_i       (wbs_adr_i),
        .wbs_dat_i       (wbs_dat_i),
        .wbs_ack_o       (wbs_ack_o),
        .wbs_dat_o       (wbs_dat_o),
        .ctrl_enable_o   (ctrl_enable_o),
        .ctrl_start_o    (ctrl_start_o),
        .snapshot_fire_o (snapshot_fire),
        .bus             (evt_bus.cfg)
    );

    hic_snapshot_gen #(.N_CH(N_CH)) i_hic_snapshot_gen (
        .wb_clk_i        (wb_clk_i),
        .wb_rst_i        (wb_rst_i),
        .snapshot_fire_i (snapshot_fire),
        .bus             (evt_bus.feed)
    );

    // One detector per channel
    for (genvar c = 0; c < N_CH; c++) begin : g_chan
        hic_evt_channel #(
            .N_CH (N_CH),
            .CH   (c)
        ) i_hic_evt_channel (
            .wb_clk_i (wb_clk_i),
            .wb_rst_i (wb_rst_i),
            .bus      (evt_bus.chan)
        );
    end

endmodule

`default_nettype wire

// ==== testbench/hic_clk_gen.sv ====
//----------------------------------------------------------------------
// Testbench clock and reset. Reset is high from time zero and drops
// on the rising edge that ends the last reset cycle.
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module hic_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Synchronous reset, released on a rising edge
    initial begin
        rst_o <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_home_inventory.sv ====
//----------------------------------------------------------------------
// Directed tests for 8 channels. Relies on the stub sample pattern, so
// each snapshot raises every sample by one.
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_home_inventory
    import hic_regmap_pkg::*;
();

    localparam int          N_CH            = 8;
    localparam int          M_SNAP          = 4;
    localparam int          ACK_LIMIT       = 8;
    localparam logic [31:0] EXP_CHIP_ID     = 32'h4849_4348;
    localparam logic [31:0] EXP_SAMPLE_BASE = 32'h0000_1000;
    // About 150 transfers of 3 cycles each, with a wide margin
    localparam int          XFER_BUDGET     = 220;
    localparam int          TIMEOUT_CYCLES  = 4 + XFER_BUDGET * 3 * 6;

    logic        wb_clk;
    logic        wb_rst;
    logic        wbs_cyc;
    logic        wbs_stb;
    logic        wbs_we;
    logic [3:0]  wbs_sel;
    logic [31:0] wbs_adr;
    logic [31:0] wbs_dat_w;
    logic        wbs_ack_o;
    logic [31:0] wbs_dat_o;
    logic        ctrl_enable_o;
    logic        ctrl_start_o;

    int          err_cnt       = 0;
    int          check_cnt     = 0;
    int          test_cnt      = 0;
    int          test_fail_cnt = 0;
    int          cycle_cnt     = 0;
    int          snap_total    = 0;
    int          thr     [N_CH];
    int          exp_cnt [N_CH];
    logic [31:0] lfsr_q        = 32'h426a_307e;

    hic_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) i_hic_clk_gen (
        .clk_o (wb_clk),
        .rst_o (wb_rst)
    );

    home_inventory_wb #(.N_CH(N_CH)) i_home_inventory_wb (
        .wb_clk_i      (wb_clk),
        .wb_rst_i      (wb_rst),
        .wbs_cyc_i     (wbs_cyc),
        .wbs_stb_i     (wbs_stb),
        .wbs_we_i      (wbs_we),
        .wbs_sel_i     (wbs_sel),
        .wbs_adr_i     (wbs_adr),
        .wbs_dat_i     (wbs_dat_w),
        .wbs_ack_o     (wbs_ack_o),
        .wbs_dat_o     (wbs_dat_o),
        .ctrl_enable_o (ctrl_enable_o),
        .ctrl_start_o  (ctrl_start_o)
    );

    //------------------------------------------------------------------
    // Checks and random bits
    //------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        check_cnt++;
        assert (cond === 1'b1) else begin
            $display("ERROR %s", msg);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        test_cnt++;
        if (err_cnt == err_start) begin
            $display("Test %s: ok", name);
        end else begin
            test_fail_cnt++;
            $display("Test %s: %0d errors", name, err_cnt - err_start);
        end
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_random(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    //------------------------------------------------------------------
    // Wishbone master
    //------------------------------------------------------------------
    task automatic wait_ack();
        int waited;
        waited = 0;
        do begin
            @(posedge wb_clk);
            waited++;
        end while (wbs_ack_o !== 1'b1 && waited < ACK_LIMIT);
        check_true(wbs_ack_o === 1'b1, "no Wishbone ack within the wait limit");
    endtask

    task automatic wb_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] sel);
        @(posedge wb_clk);
        wbs_cyc   <= 1'b1;
        wbs_stb   <= 1'b1;
        wbs_we    <= 1'b1;
        wbs_sel   <= sel;
        wbs_adr   <= addr;
        wbs_dat_w <= data;
        wait_ack();
        wbs_cyc   <= 1'b0;
        wbs_stb   <= 1'b0;
        wbs_we    <= 1'b0;
    endtask

    task automatic wb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge wb_clk);
        wbs_cyc <= 1'b1;
        wbs_stb <= 1'b1;
        wbs_we  <= 1'b0;
        wbs_sel <= 4'hF;
        wbs_adr <= addr;
        wait_ack();
        data = wbs_dat_o;
        wbs_cyc <= 1'b0;
        wbs_stb <= 1'b0;
    endtask

    task automatic take_snapshot();
        wb_write(ADR_ADC_CMD, 32'h1, 4'b0001);
        snap_total++;
    endtask

    task automatic check_counts(input string stage);
        logic [31:0] rd;
        for (int c = 0; c < N_CH; c++) begin
            wb_read(ADR_EVT_COUNT_BASE + 32'(4 * c), rd);
            check_value($sformatf("EVT_COUNT[%0d] %s", c, stage), rd, 32'(exp_cnt[c]));
        end
    endtask

    //------------------------------------------------------------------
    // Directed tests
    //------------------------------------------------------------------
    task automatic test_reset_values();
        int          e0;
        logic [31:0] rd;
        e0 = err_cnt;
        check_value("wbs_ack_o", 32'(wbs_ack_o), 32'h0);
        check_value("ctrl_enable_o", 32'(ctrl_enable_o), 32'h0);
        check_value("ctrl_start_o", 32'(ctrl_start_o), 32'h0);
        wb_read(ADR_ID, rd);
        check_value("ID", rd, EXP_CHIP_ID);
        wb_read(ADR_VERSION, rd);
        check_value("VERSION", rd, 32'h1);
        wb_read(ADR_CTRL, rd);
        check_value("CTRL", rd, 32'h0);
        wb_read(ADR_ADC_SNAPSHOT_COUNT, rd);
        check_value("SNAPSHOT_COUNT", rd, 32'h0);
        wb_read(32'h0000_0030, rd);
        check_value("unmapped 0x30", rd, 32'h0);
        wb_read(32'h0000_0200, rd);
        check_value("unmapped 0x200", rd, 32'h0);
        report_test("reset_values", e0);
    endtask

    task automatic test_ctrl();
        int          e0;
        logic [31:0] rd;
        logic [3:0]  starts;
        e0 = err_cnt;
        wb_write(ADR_CTRL, 32'h1, 4'b0001);
        check_value("ctrl_enable_o", 32'(ctrl_enable_o), 32'h1);
        wb_read(ADR_CTRL, rd);
        check_value("CTRL", rd, 32'h1);
        // Lane 0 not selected, ENABLE must hold
        wb_write(ADR_CTRL, 32'h0, 4'b1110);
        check_value("ctrl_enable_o", 32'(ctrl_enable_o), 32'h1);
        wb_read(ADR_CTRL, rd);
        check_value("CTRL", rd, 32'h1);
        // Sample start on the ack edge and the three edges after it
        wb_write(ADR_CTRL, 32'h3, 4'b0001);
        starts = '0;
        for (int i = 0; i < 4; i++) begin
            if (i > 0) begin
                @(posedge wb_clk);
            end
            starts[i] = ctrl_start_o;
        end
        check_value("ctrl_start_o pattern", 32'(starts), 32'h2);
        wb_read(ADR_CTRL, rd);
        check_value("CTRL", rd, 32'h1);
        wb_write(ADR_CTRL, 32'h0, 4'b0001);
        check_value("ctrl_enable_o", 32'(ctrl_enable_o), 32'h0);
        report_test("ctrl", e0);
    endtask

    task automatic test_snapshots();
        int          e0;
        logic [31:0] rd;
        logic [31:0] t0;
        e0 = err_cnt;
        for (int k = 0; k < 3; k++) begin
            take_snapshot();
        end
        wb_read(ADR_ADC_SNAPSHOT_COUNT, rd);
        check_value("SNAPSHOT_COUNT", rd, 32'(snap_total));
        for (int c = 0; c < N_CH; c++) begin
            wb_read(ADR_ADC_RAW_BASE + 32'(4 * c), rd);
            check_value($sformatf("ADC_RAW[%0d]", c), rd,
                        EXP_SAMPLE_BASE + 32'(snap_total) + 32'(c));
        end
        wb_read(ADR_TIME_NOW, t0);
        for (int i = 0; i < 2; i++) begin
            wb_read(ADR_TIME_NOW, rd);
            check_true(rd > t0, $sformatf("TIME_NOW did not increase, 0x%08h then 0x%08h",
                                          t0, rd));
            t0 = rd;
        end
        report_test("snapshots", e0);
    endtask

    task automatic test_events();
        int          e0;
        logic [31:0] rd;
        logic [31:0] t_before;
        logic [31:0] t_after;
        e0 = err_cnt;
        for (int c = 0; c < N_CH; c++) begin
            draw_random(2, rd);
            thr[c] = int'(rd);
            wb_write(ADR_EVT_THRESH_BASE + 32'(4 * c), rd, 4'hF);
            wb_read(ADR_EVT_THRESH_BASE + 32'(4 * c), rd);
            check_value($sformatf("EVT_THRESH[%0d]", c), rd, 32'(thr[c]));
        end
        wb_write(ADR_EVT_CFG, 32'hFF, 4'b0001);
        wb_read(ADR_EVT_CFG, rd);
        check_value("EVT_CFG", rd, 32'hFF);
        for (int i = 0; i < M_SNAP - 1; i++) begin
            take_snapshot();
        end
        wb_read(ADR_TIME_NOW, t_before);
        take_snapshot();
        wb_read(ADR_TIME_NOW, t_after);
        // First snapshot only primes, the rest step by one
        for (int c = 0; c < N_CH; c++) begin
            exp_cnt[c] = (thr[c] <= 1) ? M_SNAP - 1 : 0;
        end
        check_counts("after events");
        for (int c = 0; c < N_CH; c++) begin
            wb_read(ADR_EVT_LAST_DELTA_BASE + 32'(4 * c), rd);
            check_value($sformatf("EVT_LAST_DELTA[%0d]", c), rd,
                        (exp_cnt[c] != 0) ? 32'h1 : 32'h0);
            wb_read(ADR_EVT_LAST_TS_BASE + 32'(4 * c), rd);
            if (exp_cnt[c] != 0) begin
                check_true(rd > t_before && rd < t_after,
                           $sformatf("EVT_LAST_TS[%0d] 0x%08h not between 0x%08h and 0x%08h",
                                     c, rd, t_before, t_after));
            end else begin
                check_value($sformatf("EVT_LAST_TS[%0d]", c), rd, 32'h0);
            end
        end
        report_test("events", e0);
    endtask

    task automatic test_mask_and_clears();
        int          e0;
        logic [31:0] rd;
        e0 = err_cnt;
        // Channel 0 off, counts cleared in the same write
        wb_write(ADR_EVT_CFG, 32'h0000_01FE, 4'b0011);
        for (int c = 0; c < N_CH; c++) begin
            exp_cnt[c] = 0;
        end
        check_counts("after clear_counts");
        // History survives the count clear
        take_snapshot();
        for (int c = 1; c < N_CH; c++) begin
            exp_cnt[c] = (thr[c] <= 1) ? 1 : 0;
        end
        check_counts("after first snapshot");
        wb_write(ADR_EVT_CFG, 32'h0000_02FE, 4'b0011);
        for (int c = 0; c < N_CH; c++) begin
            wb_read(ADR_EVT_LAST_DELTA_BASE + 32'(4 * c), rd);
            check_value($sformatf("EVT_LAST_DELTA[%0d] cleared", c), rd, 32'h0);
            wb_read(ADR_EVT_LAST_TS_BASE + 32'(4 * c), rd);
            check_value($sformatf("EVT_LAST_TS[%0d] cleared", c), rd, 32'h0);
        end
        take_snapshot();
        check_counts("after priming snapshot");
        take_snapshot();
        for (int c = 1; c < N_CH; c++) begin
            exp_cnt[c] += (thr[c] <= 1) ? 1 : 0;
        end
        check_counts("after last snapshot");
        report_test("mask_and_clears", e0);
    endtask

    //------------------------------------------------------------------
    // Run control
    //------------------------------------------------------------------
    always @(posedge wb_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        wbs_cyc   <= 1'b0;
        wbs_stb   <= 1'b0;
        wbs_we    <= 1'b0;
        wbs_sel   <= 4'h0;
        wbs_adr   <= 32'h0;
        wbs_dat_w <= 32'h0;
        do begin
            @(posedge wb_clk);
        end while (wb_rst !== 1'b0);
        test_reset_values();
        test_ctrl();
        test_snapshots();
        test_events();
        test_mask_and_clears();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/hic_event_pkg.sv
src/hic_regmap_pkg.sv
src/hic_evt_bus_if.sv
src/hic_snapshot_gen.sv
src/hic_evt_channel.sv
src/hic_wb_regs.sv
src/home_inventory_wb.sv
testbench/hic_clk_gen.sv
testbench/tb_home_inventory.sv

// ==== Makefile ====
# Verilator build for the home inventory register block

VERILATOR  ?= verilator
TOP        := tb_home_inventory
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
PASS_TEXT  := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output goes to the console and the run passes only on the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
